/* verilog.f */
+incdir+src
src/dmem_pkg.sv
src/access_if.sv
src/access_arbiter.sv
src/stride_agu.sv
src/router_port.sv
src/data_mem.sv
testbench/tb_data_mem.sv

/* testbench/tb_data_mem.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module tb_data_mem;
	import dmem_pkg::*;

	localparam int CLOCK_PERIOD = 8;
	localparam int NUM_TESTS = 5;
	localparam int CYCLES_PER_TEST = 2000;

	logic clock;
	logic reset;

	// Index 1 and 2 are the local ports, index 3 is the router stream
	logic [1:2] st_req;
	logic [1:2][`DMEM_ADDR_WIDTH-1:0] st_length;
	logic [1:2][`DMEM_ADDR_WIDTH-1:0] st_stride;
	logic [1:2][`DMEM_ADDR_WIDTH-1:0] st_base;
	wire [1:2] st_grant;
	logic [1:3] st_valid;
	logic [1:3][`DMEM_DATA_WIDTH-1:0] st_data;
	wire [1:3] st_ready;
	logic [1:2] ld_req;
	logic [1:2][`DMEM_ADDR_WIDTH-1:0] ld_length;
	logic [1:2][`DMEM_ADDR_WIDTH-1:0] ld_stride;
	logic [1:2][`DMEM_ADDR_WIDTH-1:0] ld_base;
	wire [1:2] ld_grant;
	wire [1:3] ld_valid;
	wire [1:3][`DMEM_DATA_WIDTH-1:0] ld_data;
	logic [1:3] ld_ready;

	data_t model [0:`DMEM_DEPTH-1];	// Expected memory contents
	integer seed;
	string test_name;

	data_mem dut (
		.clock(clock),
		.reset(reset),
		.st_req_1(st_req[1]),
		.st_length_1(st_length[1]),
		.st_stride_1(st_stride[1]),
		.st_base_1(st_base[1]),
		.st_grant_1(st_grant[1]),
		.st_valid_1(st_valid[1]),
		.st_data_1(st_data[1]),
		.st_ready_1(st_ready[1]),
		.st_req_2(st_req[2]),
		.st_length_2(st_length[2]),
		.st_stride_2(st_stride[2]),
		.st_base_2(st_base[2]),
		.st_grant_2(st_grant[2]),
		.st_valid_2(st_valid[2]),
		.st_data_2(st_data[2]),
		.st_ready_2(st_ready[2]),
		.ld_req_1(ld_req[1]),
		.ld_length_1(ld_length[1]),
		.ld_stride_1(ld_stride[1]),
		.ld_base_1(ld_base[1]),
		.ld_grant_1(ld_grant[1]),
		.ld_valid_1(ld_valid[1]),
		.ld_data_1(ld_data[1]),
		.ld_ready_1(ld_ready[1]),
		.ld_req_2(ld_req[2]),
		.ld_length_2(ld_length[2]),
		.ld_stride_2(ld_stride[2]),
		.ld_base_2(ld_base[2]),
		.ld_grant_2(ld_grant[2]),
		.ld_valid_2(ld_valid[2]),
		.ld_data_2(ld_data[2]),
		.ld_ready_2(ld_ready[2]),
		.rt_in_valid(st_valid[3]),
		.rt_in_data(st_data[3]),
		.rt_in_ready(st_ready[3]),
		.rt_out_valid(ld_valid[3]),
		.rt_out_data(ld_data[3]),
		.rt_out_ready(ld_ready[3])
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLOCK_PERIOD);
		$display("Watchdog expired before the tests finished, the run timed out");
		$display("Test failures found");
		$fatal(1, "Simulation stopped by the watchdog");
	end

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR: %s: %s expected %h, actual %h", test_name, what, expected, actual);
			$display("Test failures found");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Word content ties the tag, the full address and the beat index
	function automatic data_t word_at(input logic [7:0] tag, input addr_t addr, input int k);
		return {tag, addr, 8'(k), addr ^ 8'h5a};
	endfunction

	// Both grants must never be high at once
	always @(posedge clock) begin
		if (!reset) begin
			check_value("store grant overlap", 0, st_grant[1] & st_grant[2]);
			check_value("load grant overlap", 0, ld_grant[1] & ld_grant[2]);
		end
	end

	task automatic apply_reset;
		reset <= 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_value("grants after reset", 0, {st_grant, ld_grant});
		check_value("store ready and load valid after reset", 0, {st_ready[1:2], ld_valid});
		check_value("router header ready after reset", 1, st_ready[3]);
	endtask

	task automatic send_header(input logic [1:0] op, input addr_t base, stride, length);
		@(posedge clock);
		st_valid[3] <= 1'b1;
		st_data[3] <= {op, 6'd0, length, stride, base};
		do @(posedge clock); while (!(st_valid[3] && st_ready[3]));
	endtask

	task automatic store_words(input int port, input addr_t base, stride, length,
			input logic [7:0] tag);
		int k;
		addr_t addr;
		if (port == 3) begin
			send_header(2'd1, base, stride, length);
		end else begin
			@(posedge clock);
			st_req[port] <= 1'b1;
			st_length[port] <= length;
			st_stride[port] <= stride;
			st_base[port] <= base;
			do @(posedge clock); while (st_grant[port] !== 1'b1);
			st_req[port] <= 1'b0;
		end
		k = 0;
		addr = base;
		st_valid[port] <= 1'b1;
		st_data[port] <= word_at(tag, addr, k);
		while (k < length) begin
			@(posedge clock);
			if (st_valid[port] && st_ready[port]) begin
				model[addr] = word_at(tag, addr, k);
				k++;
				addr = addr + stride;	// Wraps at the depth
				if (k < length) begin
					st_data[port] <= word_at(tag, addr, k);
				end else begin
					st_valid[port] <= 1'b0;
				end
			end
		end
		if (port != 3) begin
			while (st_grant[port] === 1'b1) @(posedge clock);
		end
	endtask

	task automatic load_words(input int port, input addr_t base, stride, length, input bit stall);
		int k;
		addr_t addr;
		logic held;
		data_t held_data;
		if (port == 3) begin
			send_header(2'd2, base, stride, length);
			st_valid[3] <= 1'b0;
		end else begin
			@(posedge clock);
			ld_req[port] <= 1'b1;
			ld_length[port] <= length;
			ld_stride[port] <= stride;
			ld_base[port] <= base;
			do @(posedge clock); while (ld_grant[port] !== 1'b1);
			ld_req[port] <= 1'b0;
		end
		k = 0;
		addr = base;
		held = 1'b0;
		held_data = '0;
		ld_ready[port] <= 1'b1;
		while (k < length) begin
			@(posedge clock);
			if (held) begin
				check_value("valid dropped while stalled", 1, ld_valid[port]);
				check_value("data changed while stalled", held_data, ld_data[port]);
			end
			held = ld_valid[port] & ~ld_ready[port];
			held_data = ld_data[port];
			if (ld_valid[port] && ld_ready[port]) begin
				check_value("load data", model[addr], ld_data[port]);
				k++;
				addr = addr + stride;
			end
			if (stall) begin
				ld_ready[port] <= (($random(seed) & 3) != 0);	// Low about one cycle in four
			end else begin
				ld_ready[port] <= 1'b1;
			end
		end
		ld_ready[port] <= 1'b0;
		if (port != 3) begin
			while (ld_grant[port] === 1'b1) @(posedge clock);
		end
	endtask

	task automatic test_contiguous;
		test_name = "contiguous";
		store_words(1, 8'h10, 8'd1, 8'd16, 8'h11);
		load_words(2, 8'h10, 8'd1, 8'd16, 1'b0);
	endtask

	task automatic test_strided_wrap;
		test_name = "strided_wrap";
		store_words(2, 8'hf0, 8'd5, 8'd20, 8'h22);
		load_words(1, 8'hf0, 8'd5, 8'd20, 1'b0);
		load_words(2, 8'h04, 8'd5, 8'd16, 1'b0);	// Wrapped beats from their own base
	endtask

	task automatic test_load_backpressure;
		test_name = "load_backpressure";
		store_words(2, 8'h80, 8'd1, 8'd24, 8'h33);
		load_words(1, 8'h80, 8'd1, 8'd24, 1'b1);
	endtask

	task automatic test_store_arbitration;
		test_name = "store_arbitration";
		apply_reset();
		fork
			store_words(1, 8'h40, 8'd1, 8'd8, 8'h41);
			store_words(2, 8'h60, 8'd2, 8'd8, 8'h42);
			begin
				do @(posedge clock); while (st_grant == 2'b00);
				check_value("first store grant", 2'b10, st_grant);
			end
		join
		load_words(1, 8'h40, 8'd1, 8'd8, 1'b0);
		load_words(2, 8'h60, 8'd2, 8'd8, 1'b0);
	endtask

	task automatic test_router;
		test_name = "router_store_load";
		store_words(3, 8'ha0, 8'd3, 8'd12, 8'h55);
		load_words(1, 8'ha0, 8'd3, 8'd12, 1'b0);
		store_words(1, 8'hc0, 8'd1, 8'd10, 8'h66);
		load_words(3, 8'hc0, 8'd1, 8'd10, 1'b1);
	endtask

	initial begin
		seed = 32'ha8ea_803b;
		test_name = "reset";
		clock = 1'b0;
		reset = 1'b1;
		st_req = '0;
		st_length = '0;
		st_stride = '0;
		st_base = '0;
		st_valid = '0;
		st_data = '0;
		ld_req = '0;
		ld_length = '0;
		ld_stride = '0;
		ld_base = '0;
		ld_ready = '0;
		apply_reset();
		test_contiguous();
		test_strided_wrap();
		test_load_backpressure();
		test_store_arbitration();
		test_router();
		$display("All tests passed!");
		$finish;
	end

endmodule

/* src/data_mem.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module data_mem (
	input logic clock,
	input logic reset,
	input logic st_req_1,
	input dmem_pkg::addr_t st_length_1,
	input dmem_pkg::addr_t st_stride_1,
	input dmem_pkg::addr_t st_base_1,
	output logic st_grant_1,
	input logic st_valid_1,
	input dmem_pkg::data_t st_data_1,
	output logic st_ready_1,
	input logic st_req_2,
	input dmem_pkg::addr_t st_length_2,
	input dmem_pkg::addr_t st_stride_2,
	input dmem_pkg::addr_t st_base_2,
	output logic st_grant_2,
	input logic st_valid_2,
	input dmem_pkg::data_t st_data_2,
	output logic st_ready_2,
	input logic ld_req_1,
	input dmem_pkg::addr_t ld_length_1,
	input dmem_pkg::addr_t ld_stride_1,
	input dmem_pkg::addr_t ld_base_1,
	output logic ld_grant_1,
	output logic ld_valid_1,
	output dmem_pkg::data_t ld_data_1,
	input logic ld_ready_1,
	input logic ld_req_2,
	input dmem_pkg::addr_t ld_length_2,
	input dmem_pkg::addr_t ld_stride_2,
	input dmem_pkg::addr_t ld_base_2,
	output logic ld_grant_2,
	output logic ld_valid_2,
	output dmem_pkg::data_t ld_data_2,
	input logic ld_ready_2,
	input logic rt_in_valid,
	input dmem_pkg::data_t rt_in_data,
	output logic rt_in_ready,
	output logic rt_out_valid,
	output dmem_pkg::data_t rt_out_data,
	input logic rt_out_ready
);
	import dmem_pkg::*;

	data_t mem [0:`DMEM_DEPTH-1];

	requester_t st_owner;
	requester_t ld_owner;
	logic st_start;
	logic ld_start;
	addr_t st_length;
	addr_t st_stride;
	addr_t st_base;
	addr_t ld_length;
	addr_t ld_stride;
	addr_t ld_base;
	addr_t st_address;
	addr_t ld_address;
	logic st_last;
	logic ld_last;
	logic st_active;
	logic ld_active;

	logic st_sel_valid;
	data_t st_sel_data;
	logic st_beat;
	logic rt_st_valid;
	logic rt_st_ready;
	data_t rt_st_data;

	logic rt_ld_valid;
	logic rt_ld_ready;
	logic ld_sel_ready;
	logic ld_read;
	logic ld_drain;
	logic ld_out_valid;
	logic ld_out_last;	// Held word is the final one
	data_t ld_out_data;

	access_if st_if_1 ();
	access_if st_if_2 ();
	access_if st_if_rt ();
	access_if ld_if_1 ();
	access_if ld_if_2 ();
	access_if ld_if_rt ();

	assign st_if_1.req = st_req_1;
	assign st_if_1.length = st_length_1;
	assign st_if_1.stride = st_stride_1;
	assign st_if_1.base = st_base_1;
	assign st_grant_1 = st_if_1.grant;

	assign st_if_2.req = st_req_2;
	assign st_if_2.length = st_length_2;
	assign st_if_2.stride = st_stride_2;
	assign st_if_2.base = st_base_2;
	assign st_grant_2 = st_if_2.grant;

	assign ld_if_1.req = ld_req_1;
	assign ld_if_1.length = ld_length_1;
	assign ld_if_1.stride = ld_stride_1;
	assign ld_if_1.base = ld_base_1;
	assign ld_grant_1 = ld_if_1.grant;

	assign ld_if_2.req = ld_req_2;
	assign ld_if_2.length = ld_length_2;
	assign ld_if_2.stride = ld_stride_2;
	assign ld_if_2.base = ld_base_2;
	assign ld_grant_2 = ld_if_2.grant;

	// Store steering by owner
	always_comb begin
		case (st_owner)
			REQ_PORT1: begin
				st_sel_valid = st_valid_1;
				st_sel_data = st_data_1;
			end
			REQ_PORT2: begin
				st_sel_valid = st_valid_2;
				st_sel_data = st_data_2;
			end
			REQ_ROUTER: begin
				st_sel_valid = rt_st_valid;
				st_sel_data = rt_st_data;
			end
			default: begin
				st_sel_valid = 1'b0;
				st_sel_data = '0;
			end
		endcase
	end

	assign st_ready_1 = st_active & (st_owner == REQ_PORT1);
	assign st_ready_2 = st_active & (st_owner == REQ_PORT2);
	assign rt_st_ready = st_active & (st_owner == REQ_ROUTER);
	assign st_beat = st_active & st_sel_valid;

	always_ff @(posedge clock) begin
		if (st_beat) begin
			mem[st_address] <= st_sel_data;
		end
	end

	always_comb begin
		case (ld_owner)
			REQ_PORT1: ld_sel_ready = ld_ready_1;
			REQ_PORT2: ld_sel_ready = ld_ready_2;
			REQ_ROUTER: ld_sel_ready = rt_ld_ready;
			default: ld_sel_ready = 1'b0;
		endcase
	end

	// One word in flight, refilled as it drains
	assign ld_drain = ld_out_valid & ld_sel_ready;
	assign ld_read = ld_active & (~ld_out_valid | ld_drain);

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_out_valid <= 1'b0;
			ld_out_last <= 1'b0;
		end else if (ld_read) begin
			ld_out_valid <= 1'b1;
			ld_out_last <= ld_last;
		end else if (ld_drain) begin
			ld_out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ld_read) begin
			ld_out_data <= mem[ld_address];	// Old word on a same-address write
		end
	end

	assign ld_valid_1 = ld_out_valid & (ld_owner == REQ_PORT1);
	assign ld_valid_2 = ld_out_valid & (ld_owner == REQ_PORT2);
	assign rt_ld_valid = ld_out_valid & (ld_owner == REQ_ROUTER);
	assign ld_data_1 = (ld_owner == REQ_PORT1) ? ld_out_data : '0;
	assign ld_data_2 = (ld_owner == REQ_PORT2) ? ld_out_data : '0;

	router_port router (
		.clock(clock),
		.reset(reset),
		.rt_in_valid(rt_in_valid),
		.rt_in_data(rt_in_data),
		.rt_in_ready(rt_in_ready),
		.rt_out_valid(rt_out_valid),
		.rt_out_data(rt_out_data),
		.rt_out_ready(rt_out_ready),
		.st_access(st_if_rt),
		.ld_access(ld_if_rt),
		.st_valid(rt_st_valid),
		.st_data(rt_st_data),
		.st_ready(rt_st_ready),
		.ld_valid(rt_ld_valid),
		.ld_data((ld_owner == REQ_ROUTER) ? ld_out_data : '0),
		.ld_ready(rt_ld_ready)
	);

	access_arbiter st_arbiter (
		.clock(clock),
		.reset(reset),
		.port_a(st_if_1),
		.port_b(st_if_2),
		.port_c(st_if_rt),
		.beat(st_beat),
		.last(st_last),
		.start(st_start),
		.length(st_length),
		.stride(st_stride),
		.base(st_base),
		.owner(st_owner)
	);

	// Load completes when the final word leaves the register
	access_arbiter ld_arbiter (
		.clock(clock),
		.reset(reset),
		.port_a(ld_if_1),
		.port_b(ld_if_2),
		.port_c(ld_if_rt),
		.beat(ld_drain),
		.last(ld_out_last),
		.start(ld_start),
		.length(ld_length),
		.stride(ld_stride),
		.base(ld_base),
		.owner(ld_owner)
	);

	stride_agu st_agu (
		.clock(clock),
		.reset(reset),
		.start(st_start),
		.length(st_length),
		.stride(st_stride),
		.base(st_base),
		.step(st_beat),
		.address(st_address),
		.last(st_last),
		.active(st_active)
	);

	stride_agu ld_agu (
		.clock(clock),
		.reset(reset),
		.start(ld_start),
		.length(ld_length),
		.stride(ld_stride),
		.base(ld_base),
		.step(ld_read),
		.address(ld_address),
		.last(ld_last),
		.active(ld_active)
	);

endmodule

/* src/router_port.sv */
`timescale 1ns/1ps

module router_port (
	input logic clock,
	input logic reset,
	input logic rt_in_valid,
	input dmem_pkg::data_t rt_in_data,
	output logic rt_in_ready,
	output logic rt_out_valid,
	output dmem_pkg::data_t rt_out_data,
	input logic rt_out_ready,
	access_if.requester st_access,
	access_if.requester ld_access,
	output logic st_valid,
	output dmem_pkg::data_t st_data,
	input logic st_ready,
	input logic ld_valid,
	input dmem_pkg::data_t ld_data,
	output logic ld_ready
);
	import dmem_pkg::*;

	router_op_t state;	// Command in progress
	router_word_t in_word;
	addr_t cmd_length;
	addr_t cmd_stride;
	addr_t cmd_base;
	logic st_req;
	logic ld_req;
	logic header_take;

	assign in_word = router_word_t'(rt_in_data);
	assign header_take = (state == OP_IDLE) & rt_in_valid;

	// Headers while idle, store payload while storing
	assign rt_in_ready = (state == OP_IDLE) | ((state == OP_STORE) & st_ready);
	assign st_valid = (state == OP_STORE) & rt_in_valid;
	assign st_data = in_word.data;

	assign rt_out_valid = (state == OP_LOAD) & ld_valid;
	assign rt_out_data = ld_data;
	assign ld_ready = (state == OP_LOAD) & rt_out_ready;

	assign st_access.req = st_req;
	assign st_access.length = cmd_length;
	assign st_access.stride = cmd_stride;
	assign st_access.base = cmd_base;

	assign ld_access.req = ld_req;
	assign ld_access.length = cmd_length;
	assign ld_access.stride = cmd_stride;
	assign ld_access.base = cmd_base;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= OP_IDLE;
			st_req <= 1'b0;
			ld_req <= 1'b0;
		end else begin
			case (state)
				OP_IDLE: begin
					if (header_take) begin
						case (in_word.header.op)
							OP_STORE: begin
								st_req <= 1'b1;
								state <= OP_STORE;
							end
							OP_LOAD: begin
								ld_req <= 1'b1;
								state <= OP_LOAD;
							end
							default: ;	// Dropped
						endcase
					end
				end
				OP_STORE: begin
					if (st_access.grant) begin
						st_req <= 1'b0;
					end
					if (st_access.done) begin
						state <= OP_IDLE;
					end
				end
				OP_LOAD: begin
					if (ld_access.grant) begin
						ld_req <= 1'b0;
					end
					if (ld_access.done) begin
						state <= OP_IDLE;
					end
				end
				default: state <= OP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (header_take) begin
			cmd_length <= in_word.header.length;
			cmd_stride <= in_word.header.stride;
			cmd_base <= in_word.header.base;
		end
	end

endmodule

/* src/stride_agu.sv */
`timescale 1ns/1ps

module stride_agu (
	input logic clock,
	input logic reset,
	input logic start,
	input dmem_pkg::addr_t length,
	input dmem_pkg::addr_t stride,
	input dmem_pkg::addr_t base,
	input logic step,
	output dmem_pkg::addr_t address,
	output logic last,
	output logic active
);
	import dmem_pkg::*;

	addr_t remaining;	// Beats left, current one included
	logic advance;

	assign advance = step & active;
	assign last = active & (remaining == addr_t'(1));

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			remaining <= '0;
		end else if (start) begin
			active <= 1'b1;
			remaining <= length;
		end else if (advance) begin
			remaining <= remaining - addr_t'(1);
			if (last) begin
				active <= 1'b0;
			end
		end
	end

	// Eight bit sum wraps at the memory depth
	always_ff @(posedge clock) begin
		if (start) begin
			address <= base;
		end else if (advance) begin
			address <= address + stride;
		end
	end

endmodule

/* src/access_arbiter.sv */
`timescale 1ns/1ps

module access_arbiter (
	input logic clock,
	input logic reset,
	access_if.arbiter port_a,
	access_if.arbiter port_b,
	access_if.arbiter port_c,
	input logic beat,
	input logic last,
	output logic start,
	output dmem_pkg::addr_t length,
	output dmem_pkg::addr_t stride,
	output dmem_pkg::addr_t base,
	output dmem_pkg::requester_t owner
);
	import dmem_pkg::*;

	logic [2:0] pending;
	logic [1:0] first;
	logic [1:0] cand;
	requester_t prev;
	requester_t pick;
	logic finish;

	assign pending = {port_c.req, port_b.req, port_a.req};
	assign finish = beat & last & (owner != REQ_NONE);

	always_comb begin
		case (prev)
			REQ_PORT1: first = 2'd1;
			REQ_PORT2: first = 2'd2;
			default: first = 2'd0;	// Port one after reset
		endcase
	end

	// Search starts one past the last winner
	always_comb begin
		pick = REQ_NONE;
		cand = first;
		for (int i = 0; i < 3; i++) begin
			cand = 2'((first + i) % 3);
			if (pick == REQ_NONE && pending[cand]) begin
				pick = requester_t'(cand);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			owner <= REQ_NONE;
			prev <= REQ_ROUTER;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (owner == REQ_NONE) begin
				if (pick != REQ_NONE) begin
					owner <= pick;
					prev <= pick;
					start <= 1'b1;	// AGU loads next cycle
				end
			end else if (finish) begin
				owner <= REQ_NONE;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (owner == REQ_NONE) begin
			case (pick)
				REQ_PORT1: begin
					length <= port_a.length;
					stride <= port_a.stride;
					base <= port_a.base;
				end
				REQ_PORT2: begin
					length <= port_b.length;
					stride <= port_b.stride;
					base <= port_b.base;
				end
				REQ_ROUTER: begin
					length <= port_c.length;
					stride <= port_c.stride;
					base <= port_c.base;
				end
				default: ;
			endcase
		end
	end

	assign port_a.grant = (owner == REQ_PORT1);
	assign port_b.grant = (owner == REQ_PORT2);
	assign port_c.grant = (owner == REQ_ROUTER);

	assign port_a.done = finish & (owner == REQ_PORT1);	// Owner only
	assign port_b.done = finish & (owner == REQ_PORT2);
	assign port_c.done = finish & (owner == REQ_ROUTER);

endmodule

/* src/access_if.sv */
`timescale 1ns/1ps

interface access_if;
	import dmem_pkg::*;

	logic req;	// Held until grant
	addr_t length;
	addr_t stride;
	addr_t base;
	logic grant;
	logic done;	// One cycle, on the last accepted beat

	modport requester (
		output req,
		output length,
		output stride,
		output base,
		input grant,
		input done
	);

	modport arbiter (
		input req,
		input length,
		input stride,
		input base,
		output grant,
		output done
	);

endinterface

/* src/dmem_pkg.sv */
`include "dmem_params.svh"

package dmem_pkg;

	typedef logic [`DMEM_DATA_WIDTH-1:0] data_t;
	typedef logic [`DMEM_ADDR_WIDTH-1:0] addr_t;	// Address, stride or length

	typedef enum logic [1:0] {
		REQ_PORT1,
		REQ_PORT2,
		REQ_ROUTER,
		REQ_NONE
	} requester_t;

	typedef enum logic [1:0] {
		OP_IDLE,
		OP_STORE,
		OP_LOAD
	} router_op_t;

	typedef struct packed {
		router_op_t op;
		logic [5:0] spare;
		addr_t length;
		addr_t stride;
		addr_t base;
	} router_header_t;

	// Header or payload, depending on what the adapter expects
	typedef union packed {
		router_header_t header;
		data_t data;
	} router_word_t;

endpackage

/* src/dmem_params.svh */
`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// Word width of the memory and of the router link
`define DMEM_DATA_WIDTH 32

// Number of words held by the tile memory
`define DMEM_DEPTH 256

// Address, stride and length width
// Address arithmetic wraps modulo the depth
`define DMEM_ADDR_WIDTH 8

`endif
